/* afifo_pkg.sv */
`default_nettype none

package afifo_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned DATA_WIDTH = 8;
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned ADDR_WIDTH = $clog2(FIFO_DEPTH);

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [ADDR_WIDTH:0]   ptr_t;    // msb is the wrap bit
  typedef logic [ADDR_WIDTH:0]   level_t;  // 0 .. FIFO_DEPTH

  // almost flag thresholds
  localparam level_t AFULL_LEVEL  = level_t'(12);  // afull at or above
  localparam level_t AEMPTY_LEVEL = level_t'(2);   // aempty at or below

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // gray code helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic ptr_t bin2gray(input ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction

  // each bit folds in every gray bit above it
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

`default_nettype wire

/* afifo_dpram.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_dpram (
  input  logic             wr_clk,
  input  logic             wr_accept,
  input  afifo_pkg::addr_t wr_addr,
  input  afifo_pkg::data_t wr_data,
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_accept,
  input  afifo_pkg::addr_t rd_addr,
  output afifo_pkg::data_t rd_data
);

  afifo_pkg::data_t mem [afifo_pkg::FIFO_DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port, wr_clk domain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read port, rd_clk domain
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the word at rd_addr has been written long before empty drops,
  // since the write gray pointer needs two rd_clk flops to get here
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_addr];  // one cycle read latency
    end
  end

endmodule

`default_nettype wire

/* afifo_wr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_wr_ctrl (
  input  logic             wr_clk,
  input  logic             wr_rst_n,
  input  logic             wr_en,
  input  afifo_pkg::ptr_t  rd_gray,
  output logic             wr_accept,
  output afifo_pkg::addr_t wr_addr,
  output afifo_pkg::ptr_t  wr_gray,
  output logic             full,
  output logic             afull
);

  afifo_pkg::ptr_t   wr_bin;         // binary write pointer
  afifo_pkg::ptr_t   wr_bin_next;
  afifo_pkg::ptr_t   wr_gray_next;
  afifo_pkg::ptr_t   rd_gray_s1;     // first sync stage
  afifo_pkg::ptr_t   rd_gray_s2;
  afifo_pkg::ptr_t   rd_bin_sync;
  afifo_pkg::ptr_t   full_match;
  afifo_pkg::level_t wr_level_next;
  logic              full_next;
  logic              afull_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign wr_accept = wr_en & ~full;  // writes while full are dropped

  always_comb begin
    wr_bin_next = wr_bin;
    if (wr_accept) begin
      wr_bin_next = wr_bin + afifo_pkg::ptr_t'(1);
    end
  end

  assign wr_gray_next = afifo_pkg::bin2gray(wr_bin_next);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_next;
      wr_gray <= wr_gray_next;  // registered, so only one bit moves per edge
    end
  end

  assign wr_addr = wr_bin[afifo_pkg::ADDR_WIDTH-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read pointer into wr_clk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign rd_bin_sync = afifo_pkg::gray2bin(rd_gray_s2);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // status flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // full when the write pointer is one lap ahead of the read pointer;
  // in gray code that means the top two bits differ and the rest agree
  assign full_match = {~rd_gray_s2[afifo_pkg::ADDR_WIDTH -: 2],
                       rd_gray_s2[afifo_pkg::ADDR_WIDTH-2:0]};
  assign full_next  = (wr_gray_next == full_match);

  // fill level seen from the write side, never below the true level
  assign wr_level_next = wr_bin_next - rd_bin_sync;
  assign afull_next    = (wr_level_next >= afifo_pkg::AFULL_LEVEL);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_next;
      afull <= afull_next;
    end
  end

endmodule

`default_nettype wire

/* afifo_rd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_rd_ctrl (
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_en,
  input  afifo_pkg::ptr_t  wr_gray,
  output logic             rd_accept,
  output afifo_pkg::addr_t rd_addr,
  output afifo_pkg::ptr_t  rd_gray,
  output logic             empty,
  output logic             aempty
);

  afifo_pkg::ptr_t   rd_bin;         // binary read pointer
  afifo_pkg::ptr_t   rd_bin_next;
  afifo_pkg::ptr_t   rd_gray_next;
  afifo_pkg::ptr_t   wr_gray_s1;     // first sync stage
  afifo_pkg::ptr_t   wr_gray_s2;
  afifo_pkg::ptr_t   wr_bin_sync;
  afifo_pkg::level_t rd_level_next;
  logic              empty_next;
  logic              aempty_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rd_accept = rd_en & ~empty;  // reads while empty are dropped

  always_comb begin
    rd_bin_next = rd_bin;
    if (rd_accept) begin
      rd_bin_next = rd_bin + afifo_pkg::ptr_t'(1);
    end
  end

  assign rd_gray_next = afifo_pkg::bin2gray(rd_bin_next);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_next;
      rd_gray <= rd_gray_next;
    end
  end

  // ram address is the current pointer, the word lands in rd_data next edge
  assign rd_addr = rd_bin[afifo_pkg::ADDR_WIDTH-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write pointer into rd_clk
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign wr_bin_sync = afifo_pkg::gray2bin(wr_gray_s2);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // status flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // empty when the read pointer catches the synchronized write pointer
  assign empty_next = (rd_gray_next == wr_gray_s2);

  // level seen from the read side lags writes, so it never overstates
  assign rd_level_next = wr_bin_sync - rd_bin_next;
  assign aempty_next   = (rd_level_next <= afifo_pkg::AEMPTY_LEVEL);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_next;
      aempty <= aempty_next;
    end
  end

endmodule

`default_nettype wire

/* async_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
  // write domain
  input  logic             wr_clk,
  input  logic             wr_rst_n,
  input  logic             wr_en,
  input  afifo_pkg::data_t wr_data,
  // read domain
  input  logic             rd_clk,
  input  logic             rd_rst_n,
  input  logic             rd_en,
  output afifo_pkg::data_t rd_data,
  // status
  output logic             full,
  output logic             afull,
  output logic             empty,
  output logic             aempty
);

  logic             wr_accept;
  afifo_pkg::addr_t wr_addr;
  afifo_pkg::ptr_t  wr_gray;   // crosses to rd_clk
  logic             rd_accept;
  afifo_pkg::addr_t rd_addr;
  afifo_pkg::ptr_t  rd_gray;   // crosses to wr_clk

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  afifo_wr_ctrl wr_ctrl_i (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .rd_gray   (rd_gray),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_gray   (wr_gray),
    .full      (full),
    .afull     (afull)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  afifo_rd_ctrl rd_ctrl_i (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .wr_gray   (wr_gray),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_gray   (rd_gray),
    .empty     (empty),
    .aempty    (aempty)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  afifo_dpram dpram_i (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

endmodule

`default_nettype wire

/* afifo_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_checker (
  input logic             wr_clk,
  input logic             wr_rst_n,
  input logic             rd_clk,
  input logic             rd_rst_n,
  input afifo_pkg::ptr_t  wr_gray,
  input afifo_pkg::ptr_t  rd_gray,
  input logic             wr_accept,
  input logic             rd_accept,
  input logic             full,
  input logic             empty,
  input afifo_pkg::data_t rd_data
);

  int unsigned fail_count = 0;  // number of failed assertions

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // gray pointers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1)
    else begin
      $error("wr_gray changed by more than one bit");
      fail_count = fail_count + 1;
    end

  rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1)
    else begin
      $error("rd_gray changed by more than one bit");
      fail_count = fail_count + 1;
    end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // accepts against pointers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // live pointer of the other side, not the synchronized copy
  no_write_when_full: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_accept |-> (wr_gray != {~rd_gray[afifo_pkg::ADDR_WIDTH -: 2],
                               rd_gray[afifo_pkg::ADDR_WIDTH-2:0]}))
    else begin
      $error("write accepted while the FIFO was full");
      fail_count = fail_count + 1;
    end

  no_read_when_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_accept |-> (rd_gray != wr_gray))
    else begin
      $error("read accepted while the FIFO was empty");
      fail_count = fail_count + 1;
    end

  // read register holds without a read
  rd_data_hold: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !rd_accept |=> $stable(rd_data))
    else begin
      $error("rd_data changed without a read");
      fail_count = fail_count + 1;
    end

  full_known: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    !$isunknown(full))
    else begin
      $error("full is unknown");
      fail_count = fail_count + 1;
    end

  empty_known: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    !$isunknown(empty))
    else begin
      $error("empty is unknown");
      fail_count = fail_count + 1;
    end

endmodule

bind async_fifo afifo_checker checker_i (
  .wr_clk    (wr_clk),
  .wr_rst_n  (wr_rst_n),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .wr_gray   (wr_gray),
  .rd_gray   (rd_gray),
  .wr_accept (wr_accept),
  .rd_accept (rd_accept),
  .full      (full),
  .empty     (empty),
  .rd_data   (rd_data)
);

`default_nettype wire

/* afifo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module afifo_tb;

  localparam logic [31:0] SEED      = 32'hdb871434;
  localparam int          TIMEOUT   = 200;  // rd_clk cycles
  localparam int          QUIET     = 6;
  localparam int          BURST_LEN = 40;

  logic             wr_clk;
  logic             wr_rst_n;
  logic             wr_en;
  afifo_pkg::data_t wr_data;
  logic             rd_clk;
  logic             rd_rst_n;
  logic             rd_en;
  afifo_pkg::data_t rd_data;
  logic             full;
  logic             afull;
  logic             empty;
  logic             aempty;

  afifo_pkg::data_t model_q[$];
  afifo_pkg::data_t last_read;
  int               reads_done;
  int               wr_rate;  // strobe chance out of 256
  int               rd_rate;
  logic [31:0]      wr_rng;
  logic [31:0]      rd_rng;
  logic [31:0]      main_rng;

  async_fifo dut_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    rd_clk = 1'b0;
    forever #10 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #7 wr_clk = ~wr_clk;  // 14 ns
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // failure reporting
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic stop_failed();
    $display("Test FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic abort_run(input string msg);
    $display("Error at %0t: %s", $time, msg);
    stop_failed();
  endtask

  task automatic check_data(input afifo_pkg::data_t got, input afifo_pkg::data_t exp,
                            input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_level(input afifo_pkg::level_t got, input afifo_pkg::level_t exp,
                             input string what);
    if (got !== exp) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      stop_failed();
    end
  endtask

  always @(dut_i.checker_i.fail_count) begin
    if (dut_i.checker_i.fail_count != 0) begin
      abort_run("an assertion in the bound checker failed");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // drivers 2 ns after each edge
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge wr_clk) begin
    #2;
    wr_rng  = xorshift(wr_rng);
    wr_en   = wr_rst_n && (int'(wr_rng[7:0]) < wr_rate);
    wr_data = wr_rng[15:8];
  end

  always @(posedge rd_clk) begin
    #2;
    rd_rng = xorshift(rd_rng);
    rd_en  = rd_rst_n && (int'(rd_rng[7:0]) < rd_rate);
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      if (model_q.size() >= afifo_pkg::FIFO_DEPTH) begin
        abort_run("write accepted while the model already holds a full FIFO");
      end else begin
        model_q.push_back(wr_data);
      end
    end
  end

  always @(posedge rd_clk) begin
    if (rd_rst_n && rd_en && !empty && model_q.size() == 0) begin
      abort_run("read accepted while the model is empty");
    end else begin
      if (rd_rst_n && rd_en && !empty) begin
        last_read = model_q.pop_front();
        reads_done++;
      end
      #1;
      if (rd_rst_n) begin
        check_data(rd_data, last_read, "rd_data");  // also covers hold without read
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sequencing helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic flag_value(input string name);
    if (name == "full") begin
      return full;
    end
    return empty;
  endfunction

  task automatic wait_flag(input string name, input logic value);
    int   n;
    logic f;
    n = 0;
    f = flag_value(name);
    while (f !== value && n < TIMEOUT) begin
      @(posedge rd_clk);
      #4;
      n++;
      f = flag_value(name);
    end
    if (f !== value) begin
      abort_run($sformatf("timed out waiting for %s to become %b", name, value));
    end
  endtask

  // stop the chosen sides, then wait for the flags to hold still
  task automatic settle(input logic stop_wr, input logic stop_rd);
    int         n;
    int         stable;
    logic [3:0] prev;
    logic [3:0] flags;
    if (stop_wr) wr_rate = 0;
    if (stop_rd) rd_rate = 0;
    n      = 0;
    stable = 0;
    prev   = {full, afull, empty, aempty};
    while (stable < QUIET && n < TIMEOUT) begin
      @(posedge rd_clk);
      #4;
      n++;
      flags = {full, afull, empty, aempty};
      stable = (flags === prev) ? stable + 1 : 0;
      prev = flags;
    end
    if (stable < QUIET) begin
      abort_run("status flags did not settle during a quiet period");
    end
  endtask

  task automatic compare_status();
    int count;
    count = model_q.size();
    check_flag(full, count == afifo_pkg::FIFO_DEPTH, "full");
    check_flag(afull, count >= int'(afifo_pkg::AFULL_LEVEL), "afull");
    check_flag(empty, count == 0, "empty");
    check_flag(aempty, count <= int'(afifo_pkg::AEMPTY_LEVEL), "aempty");
  endtask

  task automatic run_bursts(input int bursts);
    for (int b = 0; b < bursts; b++) begin
      main_rng = xorshift(main_rng);
      wr_rate  = int'(main_rng[7:0]) + 1;
      rd_rate  = int'(main_rng[15:8]) + 1;
      repeat (BURST_LEN) @(posedge rd_clk);
      #4;
      if (b % 4 == 3) begin
        settle(1'b1, 1'b1);
        compare_status();
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : main_seq
    int drained;
    wr_rst_n   = 1'b0;
    rd_rst_n   = 1'b0;
    wr_en      = 1'b0;
    wr_data    = '0;
    rd_en      = 1'b0;
    wr_rate    = 0;
    rd_rate    = 0;
    last_read  = '0;
    reads_done = 0;
    wr_rng     = xorshift(SEED);
    rd_rng     = xorshift(wr_rng);
    main_rng   = xorshift(rd_rng);
    repeat (2) @(posedge rd_clk);
    #2;
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;
    @(posedge rd_clk);
    #4;
    check_flag(full, 1'b0, "full after reset");
    check_flag(afull, 1'b0, "afull after reset");
    check_flag(empty, 1'b1, "empty after reset");
    check_flag(aempty, 1'b1, "aempty after reset");
    check_data(rd_data, '0, "rd_data after reset");

    run_bursts(24);

    // overflow with reads stopped while the writer keeps pushing
    settle(1'b1, 1'b1);
    wr_rate = 256;
    wait_flag("full", 1'b1);
    settle(1'b0, 1'b1);
    settle(1'b1, 1'b1);
    check_level(afifo_pkg::level_t'(model_q.size()),
                afifo_pkg::level_t'(afifo_pkg::FIFO_DEPTH), "words held when full");
    compare_status();

    // underflow by draining and then reading an empty FIFO
    drained = reads_done;
    rd_rate = 256;
    wait_flag("empty", 1'b1);
    settle(1'b1, 1'b0);
    settle(1'b1, 1'b1);
    check_level(afifo_pkg::level_t'(reads_done - drained),
                afifo_pkg::level_t'(afifo_pkg::FIFO_DEPTH), "words read after overflow");
    compare_status();
    check_data(rd_data, last_read, "rd_data after drain");

    run_bursts(24);
    settle(1'b1, 1'b1);
    compare_status();

    if (reads_done < 10 * afifo_pkg::FIFO_DEPTH) begin
      abort_run("too few words passed through to wrap the pointers");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* list.f */
afifo_pkg.sv
afifo_dpram.sv
afifo_wr_ctrl.sv
afifo_rd_ctrl.sv
async_fifo.sv
afifo_checker.sv
afifo_tb.sv
